// ==== source/hazard_pkg.sv ====
`default_nettype none

package hazard_pkg;

    // wait cycles before the memory bus counts as hung
    localparam int MEM_WAIT_LIMIT = 16;
    localparam int WAIT_CNT_W     = $clog2(MEM_WAIT_LIMIT + 1);

    typedef logic [4:0]  reg_addr_t;   // x0 reads as zero, never forwarded
    typedef logic [31:0] data_word_t;

    // register use of one instruction, all zero means bubble
    typedef struct packed {
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        logic      reg_write;
        logic      is_load;
        logic      valid;
    } instr_tag_t;

    typedef struct packed {
        logic stall_if;
        logic stall_id;
        logic stall_ex;
        logic stall_mem;
        logic stall_wb;
        logic flush_if;
        logic flush_id;
        logic bubble_ex;   // zero tag into EX on next edge
    } pipe_ctrl_t;

    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_EX   = 2'd1,
        FWD_MEM  = 2'd2,
        FWD_WB   = 2'd3
    } fwd_sel_t;

    typedef enum logic [1:0] {
        ST_RUN      = 2'd0,
        ST_MEM_WAIT = 2'd1,
        ST_FAULT    = 2'd2   // sticky until reset
    } pipe_state_t;

endpackage

`default_nettype wire

// ==== source/tag_pipeline.sv ====
`timescale 1ns/1ps
`default_nettype none

module tag_pipeline (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire hazard_pkg::instr_tag_t id_tag,
    input  wire hazard_pkg::pipe_ctrl_t ctrl,
    output hazard_pkg::instr_tag_t      ex_tag,
    output hazard_pkg::instr_tag_t      mem_tag,
    output hazard_pkg::instr_tag_t      wb_tag
);

    import hazard_pkg::*;

    logic       hold_all;   // whole pipe frozen by memory wait or fault
    instr_tag_t ex_next;

    assign hold_all = ctrl.stall_if && ctrl.stall_id && ctrl.stall_ex &&
                      ctrl.stall_mem && ctrl.stall_wb;

    // load-use and branch both squash whatever would enter EX
    always_comb begin
        if (ctrl.bubble_ex) begin
            ex_next = '0;
        end else begin
            ex_next = id_tag;
        end
    end

    // private copy of the destination tags of EX, MEM and WB
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ex_tag  <= '0;
            mem_tag <= '0;
            wb_tag  <= '0;
        end else if (!hold_all) begin
            ex_tag  <= ex_next;
            mem_tag <= ex_tag;
            wb_tag  <= mem_tag;
        end
    end

endmodule

`default_nettype wire

// ==== source/forward_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module forward_select (
    input  wire hazard_pkg::instr_tag_t id_tag,
    input  wire hazard_pkg::instr_tag_t ex_tag,
    input  wire hazard_pkg::instr_tag_t mem_tag,
    input  wire hazard_pkg::instr_tag_t wb_tag,
    input  wire hazard_pkg::data_word_t ex_result,
    input  wire hazard_pkg::data_word_t mem_result,
    input  wire hazard_pkg::data_word_t wb_result,
    output hazard_pkg::fwd_sel_t        fwd_sel_a,
    output hazard_pkg::fwd_sel_t        fwd_sel_b,
    output hazard_pkg::data_word_t      fwd_data_a,
    output hazard_pkg::data_word_t      fwd_data_b,
    output logic                        load_use
);

    import hazard_pkg::*;

    logic ex_hit_a;
    logic ex_hit_b;

    // stage produces a register that the operand reads
    function automatic logic writes_reg(input instr_tag_t tag, input reg_addr_t rs);
        return tag.valid && tag.reg_write && (tag.rd != '0) && (tag.rd == rs);
    endfunction

    // youngest producer wins, a load still in EX has nothing to give yet
    function automatic fwd_sel_t pick_stage(input reg_addr_t rs);
        fwd_sel_t sel;
        if (writes_reg(ex_tag, rs)) begin
            sel = ex_tag.is_load ? FWD_NONE : FWD_EX;
        end else if (writes_reg(mem_tag, rs)) begin
            sel = FWD_MEM;
        end else if (writes_reg(wb_tag, rs)) begin
            sel = FWD_WB;
        end else begin
            sel = FWD_NONE;
        end
        return sel;
    endfunction

    function automatic data_word_t pick_data(input fwd_sel_t sel);
        data_word_t word;
        case (sel)
            FWD_EX:  word = ex_result;
            FWD_MEM: word = mem_result;
            FWD_WB:  word = wb_result;
            default: word = '0;   // operand comes from the register file
        endcase
        return word;
    endfunction

    assign fwd_sel_a  = pick_stage(id_tag.rs1);
    assign fwd_sel_b  = pick_stage(id_tag.rs2);
    assign fwd_data_a = pick_data(fwd_sel_a);
    assign fwd_data_b = pick_data(fwd_sel_b);

    assign ex_hit_a = writes_reg(ex_tag, id_tag.rs1);
    assign ex_hit_b = writes_reg(ex_tag, id_tag.rs2);

    // consumer right behind a load needs one bubble
    assign load_use = id_tag.valid && ex_tag.is_load && (ex_hit_a || ex_hit_b);

endmodule

`default_nettype wire

// ==== source/mem_wait_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_wait_timer (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic mem_stall,
    output logic      expired
);

    import hazard_pkg::*;

    logic [WAIT_CNT_W-1:0] wait_cnt;
    logic                  at_limit;

    assign at_limit = (wait_cnt == WAIT_CNT_W'(MEM_WAIT_LIMIT));

    // consecutive wait cycles, saturates at the limit
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wait_cnt <= '0;
            expired  <= 1'b0;
        end else if (!mem_stall) begin
            wait_cnt <= '0;   // any ready cycle restarts the count
            expired  <= 1'b0;
        end else begin
            if (!at_limit) begin
                wait_cnt <= wait_cnt + 1'b1;
            end
            // high only on the edge where the count lands on the limit
            expired <= (wait_cnt == WAIT_CNT_W'(MEM_WAIT_LIMIT - 1));
        end
    end

endmodule

`default_nettype wire

// ==== source/pipe_control_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_control_fsm (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       branch_taken,
    input  wire logic       load_use,
    input  wire logic       iready_n,
    input  wire logic       dready_n,
    input  wire logic       dbusy,
    input  wire logic [1:0] ex_mem_op,   // [1] load in MEM, [0] store in MEM
    input  wire logic       expired,
    output logic            mem_stall,
    output hazard_pkg::pipe_ctrl_t ctrl,
    output logic            bus_timeout
);

    import hazard_pkg::*;

    pipe_state_t state;
    pipe_state_t state_next;

    // fetch miss, or data side not ready for the access in MEM
    assign mem_stall = iready_n ||
                       (dready_n && ex_mem_op[1]) ||
                       (dbusy && ex_mem_op[0]);

    always_comb begin
        state_next = state;
        case (state)
            ST_RUN: begin
                if (mem_stall) begin
                    state_next = ST_MEM_WAIT;
                end
            end
            ST_MEM_WAIT: begin
                if (expired) begin
                    state_next = ST_FAULT;
                end else if (!mem_stall) begin
                    state_next = ST_RUN;
                end
            end
            ST_FAULT: state_next = ST_FAULT;   // only reset gets out
            default:  state_next = ST_RUN;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= ST_RUN;
        end else begin
            state <= state_next;
        end
    end

    // priority: fault, memory wait, branch, load-use
    always_comb begin
        ctrl = '0;
        if (state == ST_FAULT) begin
            ctrl.stall_if  = 1'b1;
            ctrl.stall_id  = 1'b1;
            ctrl.stall_ex  = 1'b1;
            ctrl.stall_mem = 1'b1;
            ctrl.stall_wb  = 1'b1;
        end else if (mem_stall) begin
            ctrl.stall_if  = 1'b1;   // whole pipe waits on the bus
            ctrl.stall_id  = 1'b1;
            ctrl.stall_ex  = 1'b1;
            ctrl.stall_mem = 1'b1;
            ctrl.stall_wb  = 1'b1;
        end else if (branch_taken) begin
            // wrong-path work dies, load-use moot here
            ctrl.flush_if  = 1'b1;
            ctrl.flush_id  = 1'b1;
            ctrl.bubble_ex = 1'b1;
        end else if (load_use) begin
            ctrl.stall_if  = 1'b1;
            ctrl.stall_id  = 1'b1;
            ctrl.bubble_ex = 1'b1;   // MEM and WB keep moving
        end
    end

    assign bus_timeout = (state == ST_FAULT);

endmodule

`default_nettype wire

// ==== source/hazard_unit_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_unit_top (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire hazard_pkg::instr_tag_t id_tag,
    input  wire logic                   branch_taken,
    input  wire logic                   iready_n,
    input  wire logic                   dready_n,
    input  wire logic                   dbusy,
    input  wire logic [1:0]             ex_mem_op,
    input  wire hazard_pkg::data_word_t ex_result,
    input  wire hazard_pkg::data_word_t mem_result,
    input  wire hazard_pkg::data_word_t wb_result,
    output hazard_pkg::pipe_ctrl_t      ctrl,
    output hazard_pkg::fwd_sel_t        fwd_sel_a,
    output hazard_pkg::fwd_sel_t        fwd_sel_b,
    output hazard_pkg::data_word_t      fwd_data_a,
    output hazard_pkg::data_word_t      fwd_data_b,
    output logic                        bus_timeout
);

    import hazard_pkg::*;

    instr_tag_t ex_tag;
    instr_tag_t mem_tag;
    instr_tag_t wb_tag;
    logic       load_use;
    logic       mem_stall;
    logic       expired;

    tag_pipeline u_tag_pipeline (
        .clk     (clk),
        .rst     (rst),
        .id_tag  (id_tag),
        .ctrl    (ctrl),
        .ex_tag  (ex_tag),
        .mem_tag (mem_tag),
        .wb_tag  (wb_tag)
    );

    forward_select u_forward_select (
        .id_tag     (id_tag),
        .ex_tag     (ex_tag),
        .mem_tag    (mem_tag),
        .wb_tag     (wb_tag),
        .ex_result  (ex_result),
        .mem_result (mem_result),
        .wb_result  (wb_result),
        .fwd_sel_a  (fwd_sel_a),
        .fwd_sel_b  (fwd_sel_b),
        .fwd_data_a (fwd_data_a),
        .fwd_data_b (fwd_data_b),
        .load_use   (load_use)
    );

    mem_wait_timer u_mem_wait_timer (
        .clk       (clk),
        .rst       (rst),
        .mem_stall (mem_stall),
        .expired   (expired)
    );

    pipe_control_fsm u_pipe_control_fsm (
        .clk          (clk),
        .rst          (rst),
        .branch_taken (branch_taken),
        .load_use     (load_use),
        .iready_n     (iready_n),
        .dready_n     (dready_n),
        .dbusy        (dbusy),
        .ex_mem_op    (ex_mem_op),
        .expired      (expired),
        .mem_stall    (mem_stall),
        .ctrl         (ctrl),
        .bus_timeout  (bus_timeout)
    );

endmodule

`default_nettype wire

// ==== tests/hazard_unit_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_unit_assertions (
    input wire logic                    clk,
    input wire logic                    rst,
    input wire hazard_pkg::pipe_ctrl_t  ctrl,
    input wire hazard_pkg::pipe_state_t state,
    input wire logic                    bus_timeout
);

    import hazard_pkg::*;

    // a frozen pipe never throws work away
    property no_flush_when_frozen;
        @(posedge clk) disable iff (!rst)
            ctrl.stall_wb |-> !(ctrl.flush_if || ctrl.flush_id);
    endproperty

    // timeout is sticky, only reset clears it
    property timeout_sticky;
        @(posedge clk) $fell(bus_timeout) |-> !rst;
    endproperty

    property no_bubble_in_fault;
        @(posedge clk) disable iff (!rst)
            (state == ST_FAULT) |-> !ctrl.bubble_ex;
    endproperty

    assert property (no_flush_when_frozen)
        else $error("flush raised while stall_wb is high");
    assert property (timeout_sticky)
        else $error("bus_timeout fell without a reset");
    assert property (no_bubble_in_fault)
        else $error("bubble_ex raised in the fault state");

endmodule

`default_nettype wire

// ==== tests/hazard_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_unit_tb;

    import hazard_pkg::*;

    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 10;
    localparam int RAND_CYCLES     = 400;
    localparam int WAIT_CYCLES     = 5;     // short memory waits well below the limit
    localparam int DIRECTED_CYCLES = 150;
    localparam int MARGIN_CYCLES   = 100;
    localparam int WATCHDOG_NS     = (2 * RESET_CYCLES + RAND_CYCLES + DIRECTED_CYCLES +
                                      MARGIN_CYCLES) * CLK_PERIOD;

    // {stall_if, stall_id, stall_ex, stall_mem, stall_wb, flush_if, flush_id, bubble_ex}
    localparam pipe_ctrl_t CTRL_IDLE     = 8'b0000_0000;
    localparam pipe_ctrl_t CTRL_FREEZE   = 8'b1111_1000;
    localparam pipe_ctrl_t CTRL_FLUSH    = 8'b0000_0111;
    localparam pipe_ctrl_t CTRL_LOAD_USE = 8'b1100_0001;

    typedef struct packed {
        pipe_ctrl_t ctrl;
        fwd_sel_t   sel_a;
        fwd_sel_t   sel_b;
        data_word_t data_a;
        data_word_t data_b;
        logic       timeout;
    } expect_t;

    logic       clk = 1'b0;
    logic       rst;
    instr_tag_t id_tag;
    logic       branch_taken;
    logic       iready_n;
    logic       dready_n;
    logic       dbusy;
    logic [1:0] ex_mem_op;
    data_word_t ex_result;
    data_word_t mem_result;
    data_word_t wb_result;
    pipe_ctrl_t ctrl;
    fwd_sel_t   fwd_sel_a;
    fwd_sel_t   fwd_sel_b;
    data_word_t fwd_data_a;
    data_word_t fwd_data_b;
    logic       bus_timeout;

    instr_tag_t sh_ex;          // shadow of the DUT's stage tags
    instr_tag_t sh_mem;
    instr_tag_t sh_wb;
    int         sh_run = 0;     // consecutive wait edges
    logic       sh_limit_hit;
    logic       sh_fault;
    expect_t    want;
    logic       cur_ms;
    string      test_name = "reset";
    int         fail_count = 0;

    hazard_unit_top DUT (.*);

    bind pipe_control_fsm hazard_unit_assertions u_assertions (
        .clk         (clk),
        .rst         (rst),
        .ctrl        (ctrl),
        .state       (state),
        .bus_timeout (bus_timeout)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic compare_value(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            fail_count++;
            $display("mismatch in %s, %s: expected %h, actual %h",
                     test_name, what, expected, actual);
            $display("Something failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // youngest writer of rs that is not x0
    function automatic fwd_sel_t youngest_writer(input reg_addr_t rs, input instr_tag_t ex,
                                                 input instr_tag_t mem, input instr_tag_t wb);
        fwd_sel_t sel;
        sel = FWD_NONE;
        if (rs != 5'd0) begin
            if (ex.valid && ex.reg_write && ex.rd == rs) begin
                sel = ex.is_load ? FWD_NONE : FWD_EX;   // load data not back yet
            end else if (mem.valid && mem.reg_write && mem.rd == rs) begin
                sel = FWD_MEM;
            end else if (wb.valid && wb.reg_write && wb.rd == rs) begin
                sel = FWD_WB;
            end
        end
        return sel;
    endfunction

    function automatic data_word_t stage_word(input fwd_sel_t sel, input data_word_t exr,
                                              input data_word_t memr, input data_word_t wbr);
        case (sel)
            FWD_EX:  return exr;
            FWD_MEM: return memr;
            FWD_WB:  return wbr;
            default: return '0;
        endcase
    endfunction

    function automatic expect_t expected_outputs(input instr_tag_t id, input instr_tag_t ex,
                                                 input instr_tag_t mem, input instr_tag_t wb,
                                                 input logic br, input logic ms,
                                                 input logic fault);
        expect_t e;
        logic    lu;
        e = '0;
        e.sel_a  = youngest_writer(id.rs1, ex, mem, wb);
        e.sel_b  = youngest_writer(id.rs2, ex, mem, wb);
        e.data_a = stage_word(e.sel_a, ex_result, mem_result, wb_result);
        e.data_b = stage_word(e.sel_b, ex_result, mem_result, wb_result);
        lu = id.valid && ex.valid && ex.reg_write && ex.is_load && ex.rd != 5'd0 &&
             (ex.rd == id.rs1 || ex.rd == id.rs2);
        if (fault || ms) begin
            e.ctrl = CTRL_FREEZE;
        end else if (br) begin
            e.ctrl = CTRL_FLUSH;       // branch wins over load-use
        end else if (lu) begin
            e.ctrl = CTRL_LOAD_USE;
        end
        e.timeout = fault;
        return e;
    endfunction

    // compare mid-cycle while inputs and outputs are settled
    always @(negedge clk) begin
        cur_ms = iready_n || (dready_n && ex_mem_op[1]) || (dbusy && ex_mem_op[0]);
        want = expected_outputs(id_tag, sh_ex, sh_mem, sh_wb, branch_taken, cur_ms, sh_fault);
        if (rst) begin
            compare_value("ctrl", 32'(want.ctrl), 32'(ctrl));
            compare_value("fwd_sel_a", 32'(want.sel_a), 32'(fwd_sel_a));
            compare_value("fwd_sel_b", 32'(want.sel_b), 32'(fwd_sel_b));
            compare_value("fwd_data_a", want.data_a, fwd_data_a);
            compare_value("fwd_data_b", want.data_b, fwd_data_b);
            compare_value("bus_timeout", 32'(want.timeout), 32'(bus_timeout));
        end
    end

    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            sh_ex        <= '0;
            sh_mem       <= '0;
            sh_wb        <= '0;
            sh_run       <= 0;
            sh_limit_hit <= 1'b0;
            sh_fault     <= 1'b0;
        end else begin
            if (want.ctrl != CTRL_FREEZE) begin
                sh_ex  <= want.ctrl.bubble_ex ? '0 : id_tag;
                sh_mem <= sh_ex;
                sh_wb  <= sh_mem;
            end
            sh_fault     <= sh_fault || sh_limit_hit;   // edge after the limit pulse
            sh_limit_hit <= cur_ms && (sh_run + 1 == MEM_WAIT_LIMIT);
            sh_run       <= cur_ms ? sh_run + 1 : 0;
        end
    end

    function automatic instr_tag_t make_tag(input int rs1, input int rs2, input int rd,
                                            input logic wr, input logic ld);
        instr_tag_t t;
        t.rs1       = reg_addr_t'(rs1);
        t.rs2       = reg_addr_t'(rs2);
        t.rd        = reg_addr_t'(rd);
        t.reg_write = wr;
        t.is_load   = ld;
        t.valid     = 1'b1;
        return t;
    endfunction

    // small register range so stages collide often
    function automatic instr_tag_t random_tag();
        instr_tag_t t;
        t.rs1       = reg_addr_t'($urandom_range(7, 0));
        t.rs2       = reg_addr_t'($urandom_range(7, 0));
        t.rd        = reg_addr_t'($urandom_range(7, 0));
        t.reg_write = 1'($urandom_range(1, 0));
        t.is_load   = ($urandom_range(3, 0) == 0);
        t.valid     = ($urandom_range(7, 0) != 0);
        return t;
    endfunction

    task automatic drive(input instr_tag_t tag, input logic br);
        @(posedge clk);
        id_tag       <= tag;
        branch_taken <= br;
        ex_result    <= $urandom;
        mem_result   <= $urandom;
        wb_result    <= $urandom;
    endtask

    task automatic set_mem(input logic ir, input logic dr, input logic db, input logic [1:0] op);
        iready_n  <= ir;
        dready_n  <= dr;
        dbusy     <= db;
        ex_mem_op <= op;
    endtask

    task automatic flush_pipe();
        repeat (3) drive('0, 1'b0);
    endtask

    task automatic mem_wait(input string name, input instr_tag_t tag, input logic ir,
                            input logic dr, input logic db, input logic [1:0] op,
                            input logic stalls);
        fwd_sel_t held;
        test_name = name;
        drive(tag, 1'b0);
        set_mem(ir, dr, db, op);
        @(negedge clk);
        held = youngest_writer(tag.rs1, sh_ex, sh_mem, sh_wb);
        repeat (WAIT_CYCLES) begin
            compare_value("stall levels", 32'(stalls ? CTRL_FREEZE : CTRL_IDLE), 32'(ctrl));
            if (stalls) begin
                compare_value("held select", 32'(held), 32'(fwd_sel_a));
            end
            drive(tag, 1'b0);
            @(negedge clk);
        end
        drive(tag, 1'b0);
        set_mem(1'b0, 1'b0, 1'b0, 2'b00);
    endtask

    initial begin
        void'($urandom(32'h18d9eeaa));
        rst          = 1'b0;
        id_tag       = '0;
        branch_taken = 1'b0;
        iready_n     = 1'b0;
        dready_n     = 1'b0;
        dbusy        = 1'b0;
        ex_mem_op    = 2'b00;
        ex_result    = '0;
        mem_result   = '0;
        wb_result    = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b1;

        test_name = "forward_priority";
        repeat (RAND_CYCLES) drive(random_tag(), 1'b0);

        test_name = "load_use";
        flush_pipe();
        drive(make_tag(1, 0, 5, 1'b1, 1'b1), 1'b0);
        drive(make_tag(5, 2, 8, 1'b1, 1'b0), 1'b0);
        @(negedge clk);
        compare_value("bubble cycle", 32'(CTRL_LOAD_USE), 32'(ctrl));
        drive(make_tag(5, 2, 8, 1'b1, 1'b0), 1'b0);   // consumer held in ID
        @(negedge clk);
        compare_value("load in MEM", 32'(FWD_MEM), 32'(fwd_sel_a));

        test_name = "branch_flush";
        flush_pipe();
        drive(make_tag(1, 0, 6, 1'b1, 1'b1), 1'b0);
        drive(make_tag(0, 6, 7, 1'b1, 1'b0), 1'b1);
        @(negedge clk);
        compare_value("flush levels", 32'(CTRL_FLUSH), 32'(ctrl));
        drive(make_tag(7, 6, 0, 1'b0, 1'b0), 1'b0);
        @(negedge clk);
        compare_value("flushed writer", 32'(FWD_NONE), 32'(fwd_sel_a));
        compare_value("load past bubble", 32'(FWD_MEM), 32'(fwd_sel_b));

        flush_pipe();
        drive(make_tag(0, 0, 3, 1'b1, 1'b0), 1'b0);
        mem_wait("load_wait", make_tag(3, 0, 4, 1'b1, 1'b0), 1'b0, 1'b1, 1'b0, 2'b10, 1'b1);
        mem_wait("store_no_dready", make_tag(3, 0, 4, 1'b1, 1'b0), 1'b0, 1'b1, 1'b0, 2'b01,
                 1'b0);
        mem_wait("fetch_wait", make_tag(4, 3, 9, 1'b1, 1'b0), 1'b1, 1'b0, 1'b0, 2'b00, 1'b1);
        mem_wait("store_busy", make_tag(4, 3, 9, 1'b1, 1'b0), 1'b0, 1'b0, 1'b1, 2'b01, 1'b1);

        test_name = "bus_timeout";
        drive(make_tag(1, 2, 3, 1'b1, 1'b0), 1'b0);
        set_mem(1'b0, 1'b1, 1'b0, 2'b10);
        for (int i = 0; i <= MEM_WAIT_LIMIT + 2; i++) begin
            @(negedge clk);
            compare_value("timeout edge", 32'(i > MEM_WAIT_LIMIT), 32'(bus_timeout));
            @(posedge clk);
        end
        set_mem(1'b0, 1'b0, 1'b0, 2'b00);
        repeat (3) begin
            @(negedge clk);
            compare_value("timeout sticky", 32'(1), 32'(bus_timeout));
            @(posedge clk);
        end
        rst <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        compare_value("timeout after reset", 32'(0), 32'(bus_timeout));
        flush_pipe();

        if (fail_count == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("Something failed");
            $fatal(1, "checks failed during the run");
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Something failed");
        $fatal(1, "watchdog expired before the test sequence finished");
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
source/hazard_pkg.sv
source/tag_pipeline.sv
source/forward_select.sv
source/mem_wait_timer.sv
source/pipe_control_fsm.sv
source/hazard_unit_top.sv
tests/hazard_unit_assertions.sv
tests/hazard_unit_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the hazard unit testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module hazard_unit_tb -f filelist.f -o hazard_unit_sim &&
./obj_dir/hazard_unit_sim || exit 1
